// File: list.f
+incdir+verilog
verilog/addrgen_cfg_pkg.sv
verilog/addrgen_beat_pkg.sv
verilog/addr_beat_if.sv
verilog/addrgen_loop_counter.sv
verilog/addrgen_strobe_gen.sv
verilog/addrgen_top.sv
dv/addrgen_assertions.sv
dv/addrgen_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the address generator testbench with Verilator and run it.
# Exits non-zero when the build, the run or any check fails.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log
SIM=addrgen_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module addrgen_tb \
  -f list.f \
  -Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM" 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

echo "simulation finished without failures"
exit 0

// File: dv/addrgen_tb.sv
/*
 * Testbench for the strided address generator.
 * Loads a configuration with clear, requests beats with enable and
 * checks every output beat against a reference model of the loop
 * rule, including its arrival two cycles after the enable.
 */

`timescale 1ns/1ps
`include "addrgen_defs.svh"

module addrgen_tb
  import addrgen_cfg_pkg::*;
();

  typedef struct packed {
    logic [`ADDRGEN_ADDR_W-1:0] addr;
    logic [`ADDRGEN_STEP-1:0]   strb;
    logic                       first;
    logic                       last;
    logic                       final_beat;
  } exp_beat_t;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       clear_i;
  logic                       enable_i;
  logic [`ADDRGEN_ADDR_W-1:0] base_addr_i;
  logic [`ADDRGEN_CNT_W-1:0]  line_length_i;
  logic [`ADDRGEN_CNT_W-1:0]  line_stride_i;
  logic [`ADDRGEN_CNT_W-1:0]  feat_length_i;
  logic [`ADDRGEN_CNT_W-1:0]  feat_stride_i;
  logic [`ADDRGEN_CNT_W-1:0]  feat_count_i;
  logic [`ADDRGEN_ADDR_W-1:0] addr_o;
  logic [`ADDRGEN_STEP-1:0]   strb_o;
  logic                       valid_o;
  logic                       first_o;
  logic                       last_o;
  logic                       busy_o;
  logic                       done_o;

  exp_beat_t    exp_q[$];
  int           due_q[$]; // cycle in which each beat must show up
  addrgen_cfg_t cur_cfg;
  logic [31:0]  lfsr_q;
  int cyc = 0;
  int wd_limit = 1000;
  int next_idx = 0;
  int total_beats = 0;
  int err_cnt = 0;
  int rx_cnt = 0;
  int done_cnt = 0;
  int test_cnt = 0;
  int err0;
  int rx0;
  int done0;
  int beat_sum;

  addrgen_top dut_i (.*);

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // cycle count and watchdog
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc > wd_limit) begin
      $display("watchdog expired after %0d cycles, the beats did not complete", cyc);
      $display("TEST FAIL");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic is_misaligned(input addrgen_cfg_t c);
    return (c.base_addr[1:0] != 2'b00) || (c.line_stride[1:0] != 2'b00) ||
           (c.feat_stride[1:0] != 2'b00);
  endfunction

  function automatic int beats_of(input addrgen_cfg_t c);
    int per_line;
    per_line = int'(c.line_length) + (is_misaligned(c) ? 1 : 0);
    return per_line * int'(c.feat_length) * int'(c.feat_count);
  endfunction

  // expected beat number n of a transfer
  function automatic exp_beat_t ref_beat(input addrgen_cfg_t c, input int n);
    exp_beat_t          b;
    logic               mis;
    int                 per_line;
    int                 w;
    int                 l;
    int                 f;
    logic signed [31:0] ls;
    logic signed [31:0] fs;
    logic [31:0]        byte_addr;
    logic [3:0]         head;
    mis = is_misaligned(c);
    per_line = int'(c.line_length) + (mis ? 1 : 0);
    w = n % per_line;
    l = (n / per_line) % int'(c.feat_length);
    f = n / (per_line * int'(c.feat_length));
    ls = c.line_stride; // sign extended
    fs = c.feat_stride;
    byte_addr = c.base_addr + f * fs + l * ls + w * 4;
    head = 4'hf << byte_addr[1:0];
    b.addr = {byte_addr[31:2], 2'b00};
    b.first = mis && (w == 0);
    b.last = mis && (w == per_line - 1);
    b.strb = b.first ? head : (b.last ? ~head : 4'hf);
    b.final_beat = (n == beats_of(c) - 1);
    return b;
  endfunction

  function automatic addrgen_cfg_t make_cfg(input logic [31:0] base, input int ll,
                                            input logic [15:0] ls, input int fl,
                                            input logic [15:0] fs, input int fc);
    addrgen_cfg_t c;
    c.base_addr = base;
    c.line_length = 16'(ll);
    c.line_stride = ls;
    c.feat_length = 16'(fl);
    c.feat_stride = fs;
    c.feat_count = 16'(fc);
    return c;
  endfunction

  task automatic rand_cfg(output addrgen_cfg_t c);
    logic [31:0] r;
    take_bits(32, r);
    c.base_addr = r;
    take_bits(2, r);
    c.line_length = 16'(r + 1);
    take_bits(16, r);
    c.line_stride = r[15:0];
    take_bits(2, r);
    c.feat_length = 16'(r + 1);
    take_bits(16, r);
    c.feat_stride = r[15:0];
    take_bits(1, r);
    c.feat_count = 16'(r + 1);
  endtask

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // compare outputs in the middle of the cycle
  always @(negedge clk_i) begin
    exp_beat_t e;
    int        due;
    if (rst_ni && valid_o) begin
      rx_cnt++;
      if (done_o) begin
        done_cnt++;
      end
      assert (exp_q.size() != 0) else begin
        $display("at %0d ns valid_o came with no beat outstanding", $time);
        err_cnt++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        due = due_q.pop_front();
        check_field("valid_o cycle", due, cyc);
        check_field("addr_o", e.addr, addr_o);
        check_field("strb_o", e.strb, strb_o);
        check_field("first_o", e.first, first_o);
        check_field("last_o", e.last, last_o);
        check_field("done_o", e.final_beat, done_o);
      end
    end else if (rst_ni && exp_q.size() != 0) begin
      assert (due_q[0] >= cyc) else begin
        $display("at %0d ns the beat due in cycle %0d never appeared", $time, due_q[0]);
        err_cnt++;
      end
      if (due_q[0] < cyc) begin
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  task automatic load_cfg(input addrgen_cfg_t c);
    @(posedge clk_i);
    // beats requested in the last cycle are flushed by the clear
    while (due_q.size() != 0 && due_q[$] >= cyc + 2) begin
      void'(due_q.pop_back());
      void'(exp_q.pop_back());
    end
    base_addr_i <= c.base_addr;
    line_length_i <= c.line_length;
    line_stride_i <= c.line_stride;
    feat_length_i <= c.feat_length;
    feat_stride_i <= c.feat_stride;
    feat_count_i <= c.feat_count;
    clear_i <= 1'b1;
    enable_i <= 1'b0;
    cur_cfg = c;
    next_idx = 0;
    total_beats = beats_of(c);
    wd_limit = wd_limit + 64 * total_beats;
    @(posedge clk_i);
    clear_i <= 1'b0;
  endtask

  // leaves enable high after the last request
  task automatic request(input int n, input bit gaps);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      if (gaps) begin
        take_bits(2, r);
        repeat (int'(r)) begin
          @(posedge clk_i);
          enable_i <= 1'b0;
        end
      end
      @(posedge clk_i);
      enable_i <= 1'b1;
      if (next_idx < total_beats) begin // enables while idle give nothing
        exp_q.push_back(ref_beat(cur_cfg, next_idx));
        due_q.push_back(cyc + 3);
        next_idx++;
      end
    end
  endtask

  task automatic drain();
    @(posedge clk_i);
    enable_i <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
  endtask

  task automatic start_test();
    err0 = err_cnt;
    rx0 = rx_cnt;
    done0 = done_cnt;
  endtask

  task automatic finish_test(input string name, input int exp_beats);
    assert (rx_cnt - rx0 == exp_beats) else begin
      $display("%s gave %0d beats instead of %0d", name, rx_cnt - rx0, exp_beats);
      err_cnt++;
    end
    test_cnt++;
    $display("test %0d %s: %0d beats, %0d errors", test_cnt, name, rx_cnt - rx0,
             err_cnt - err0);
  endtask

  initial begin
    addrgen_cfg_t c;
    lfsr_q = 32'h9fd00d19;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    enable_i = 1'b0;
    base_addr_i = '0;
    line_length_i = '0;
    line_stride_i = '0;
    feat_length_i = '0;
    feat_stride_i = '0;
    feat_count_i = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    start_test();
    load_cfg(make_cfg(32'h0000_1000, 4, 16'h0040, 3, 16'h0200, 2));
    request(24, 1'b0);
    drain();
    finish_test("aligned stride walk", 4 * 3 * 2);

    start_test();
    load_cfg(make_cfg(32'h0000_2001, 3, 16'h0020, 2, 16'h0100, 2));
    request(16, 1'b0);
    drain();
    load_cfg(make_cfg(32'h0000_3000, 2, 16'h0015, 3, 16'h0040, 1)); // odd line stride
    request(9, 1'b0);
    drain();
    finish_test("misaligned lines", 16 + 9);

    start_test();
    load_cfg(make_cfg(32'h0000_8000, 2, 16'hffd0, 3, 16'hfc00, 2));
    request(12, 1'b0);
    drain();
    load_cfg(make_cfg(32'h0000_9000, 3, 16'hfffa, 2, 16'hff00, 1));
    request(8, 1'b0);
    drain();
    finish_test("negative strides", 12 + 8);

    start_test();
    beat_sum = 0;
    for (int i = 0; i < 4; i++) begin
      rand_cfg(c);
      load_cfg(c);
      request(total_beats, 1'b1);
      drain();
      beat_sum += beats_of(c);
    end
    finish_test("random gaps and configurations", beat_sum);

    start_test();
    load_cfg(make_cfg(32'h0000_4003, 1, 16'h0008, 2, 16'h0020, 2));
    request(8 + 3, 1'b0); // three enables past the end
    drain();
    @(negedge clk_i);
    assert (busy_o == 1'b0 && done_cnt - done0 == 1) else begin
      $display("completion: busy_o %b, done_o seen %0d times", busy_o, done_cnt - done0);
      err_cnt++;
    end
    finish_test("completion", 8);

    start_test();
    load_cfg(make_cfg(32'h0000_6000, 4, 16'h0040, 2, 16'h0100, 2));
    request(5, 1'b0);
    load_cfg(make_cfg(32'h0000_5002, 2, 16'h0010, 2, 16'h0080, 1)); // last request flushed
    request(6, 1'b0);
    drain();
    finish_test("clear mid-transfer", 4 + 6);

    err_cnt += dut_i.asrt_i.fail_cnt; // concurrent assertion failures
    $display("%0d tests, %0d beats checked, %0d errors", test_cnt, rx_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: dv/addrgen_assertions.sv
/*
 * Concurrent checks on the address generator outputs.
 * Bound into every addrgen_top instance by the bind below.
 */

`timescale 1ns/1ps
`include "addrgen_defs.svh"

module addrgen_assertions (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     clear_i,
  input logic                     valid_o,
  input logic                     done_o,
  input logic                     busy_o,
  input logic                     first_o,
  input logic                     last_o,
  input logic [`ADDRGEN_STEP-1:0] strb_o
);

  int fail_cnt = 0;

  no_valid_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !valid_o)
    else begin
      fail_cnt++;
      $error("valid_o high during reset");
    end

  done_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> valid_o)
    else begin
      fail_cnt++;
      $error("done_o without valid_o");
    end

  // transfer over once the final beat is out
  idle_at_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> !busy_o)
    else begin
      fail_cnt++;
      $error("busy_o still high at done_o");
    end

  // only a clear can restart the generator
  idle_until_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!busy_o && !clear_i) |=> !busy_o)
    else begin
      fail_cnt++;
      $error("busy_o rose without a clear");
    end

  full_strobe_mid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!first_o && !last_o) |-> (strb_o == '1))
    else begin
      fail_cnt++;
      $error("partial strobe on a middle beat");
    end

endmodule

bind addrgen_top addrgen_assertions asrt_i (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .clear_i (clear_i),
  .valid_o (valid_o),
  .done_o  (done_o),
  .busy_o  (busy_o),
  .first_o (first_o),
  .last_o  (last_o),
  .strb_o  (strb_o)
);

// File: verilog/addrgen_top.sv
/*
 * Strided address generator, top level.
 * Load the configuration with a clear pulse, then pulse enable
 * once per beat while busy is high. Every beat comes out two
 * cycles after its enable, done marks the final one.
 */

`timescale 1ns/1ps
`include "addrgen_defs.svh"

module addrgen_top
  import addrgen_cfg_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       enable_i,
  input  logic [`ADDRGEN_ADDR_W-1:0] base_addr_i,
  input  logic [`ADDRGEN_CNT_W-1:0]  line_length_i,
  input  logic [`ADDRGEN_CNT_W-1:0]  line_stride_i,
  input  logic [`ADDRGEN_CNT_W-1:0]  feat_length_i,
  input  logic [`ADDRGEN_CNT_W-1:0]  feat_stride_i,
  input  logic [`ADDRGEN_CNT_W-1:0]  feat_count_i,
  output logic [`ADDRGEN_ADDR_W-1:0] addr_o,
  output logic [`ADDRGEN_STEP-1:0]   strb_o,
  output logic                       valid_o,
  output logic                       first_o,
  output logic                       last_o,
  output logic                       busy_o,
  output logic                       done_o
);

  addrgen_cfg_t cfg;

  always_comb begin
    cfg.base_addr   = base_addr_i;
    cfg.line_length = line_length_i;
    cfg.line_stride = line_stride_i; // raw bits, signed in the struct
    cfg.feat_length = feat_length_i;
    cfg.feat_stride = feat_stride_i;
    cfg.feat_count  = feat_count_i;
  end

  addr_beat_if beat_if ();

  addrgen_loop_counter loop_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .enable_i (enable_i),
    .cfg_i    (cfg),
    .beat_o   (beat_if),
    .busy_o   (busy_o)
  );

  addrgen_strobe_gen strobe_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .beat_i  (beat_if),
    .addr_o  (addr_o),
    .strb_o  (strb_o),
    .valid_o (valid_o),
    .first_o (first_o),
    .last_o  (last_o),
    .done_o  (done_o)
  );

endmodule

// File: verilog/addrgen_strobe_gen.sv
/*
 * Second pipeline stage of the address generator.
 * Splits the beat address into word index and byte offset,
 * clears the offset on the output and builds the byte strobe.
 * First and last beats of a misaligned line get partial strobes.
 */

`timescale 1ns/1ps
`include "addrgen_defs.svh"

module addrgen_strobe_gen
  import addrgen_beat_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  addr_beat_if.consumer              beat_i,
  output logic [`ADDRGEN_ADDR_W-1:0] addr_o,
  output logic [`ADDRGEN_STEP-1:0]   strb_o,
  output logic                       valid_o,
  output logic                       first_o,
  output logic                       last_o,
  output logic                       done_o
);

  logic [WORD_W-1:0]        word_idx;
  logic [OFFS_W-1:0]        byte_offs;
  logic [`ADDRGEN_STEP-1:0] strb_head; // bytes from the offset upwards
  logic [`ADDRGEN_STEP-1:0] strb_d;
  logic                     first_d;
  logic                     last_d;

  assign word_idx  = beat_i.addr.split.word;
  assign byte_offs = beat_i.addr.split.offs;
  assign strb_head = {`ADDRGEN_STEP{1'b1}} << byte_offs;

  // marks only count on a misaligned transfer
  assign first_d = beat_i.misalign & beat_i.mark.first;
  assign last_d  = beat_i.misalign & beat_i.mark.last;

  always_comb begin
    strb_d = '1;
    if (first_d) begin
      strb_d = strb_head;
    end else if (last_d) begin
      strb_d = ~strb_head; // lower bytes left over from the first beat
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
      done_o  <= 1'b0;
      first_o <= 1'b0;
      last_o  <= 1'b0;
      strb_o  <= '1;
    end else if (clear_i) begin
      valid_o <= 1'b0; // flush
      done_o  <= 1'b0;
    end else begin
      valid_o <= beat_i.valid;
      done_o  <= beat_i.valid & beat_i.mark.final_beat;
      if (beat_i.valid) begin
        first_o <= first_d;
        last_o  <= last_d;
        strb_o  <= strb_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_i.valid) begin
      addr_o <= {word_idx, {OFFS_W{1'b0}}}; // word aligned
    end
  end

endmodule

// File: verilog/addrgen_loop_counter.sv
/*
 * First pipeline stage of the address generator.
 * Holds the configuration loaded on clear and walks the
 * word / line / feature loop nest, one beat per accepted enable.
 * The beat leaves registered, one cycle after its enable,
 * with the unaligned byte address and its loop position marks.
 */

`timescale 1ns/1ps
`include "addrgen_defs.svh"

module addrgen_loop_counter
  import addrgen_cfg_pkg::*;
  import addrgen_beat_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  logic          enable_i,
  input  addrgen_cfg_t  cfg_i,
  addr_beat_if.producer beat_o,
  output logic          busy_o
);

  localparam logic [`ADDRGEN_CNT_W-1:0] CNT_ONE = 1;

  addrgen_cfg_t cfg_q;
  misalign_t    misalign_q;

  logic [`ADDRGEN_CNT_W-1:0] word_cnt;
  logic [`ADDRGEN_CNT_W-1:0] line_cnt;
  logic [`ADDRGEN_CNT_W-1:0] feat_left; // features not yet finished
  logic [`ADDRGEN_CNT_W-1:0] word_lim;

  logic [`ADDRGEN_ADDR_W-1:0] word_off;
  logic [`ADDRGEN_ADDR_W-1:0] line_off;
  logic [`ADDRGEN_ADDR_W-1:0] feat_off;
  logic [`ADDRGEN_ADDR_W-1:0] addr_d;

  logic signed [`ADDRGEN_ADDR_W-1:0] line_step;
  logic signed [`ADDRGEN_ADDR_W-1:0] feat_step;

  logic       accept;
  logic       word_wrap;
  logic       line_wrap;
  logic       feat_last;
  beat_mark_t mark_d;

  // strides widen with their sign
  assign line_step = cfg_q.line_stride;
  assign feat_step = cfg_q.feat_stride;

  // one extra word slot per line when misaligned
  assign word_lim  = misalign_q ? cfg_q.line_length : cfg_q.line_length - CNT_ONE;
  assign word_wrap = (word_cnt == word_lim);
  assign line_wrap = (line_cnt == cfg_q.feat_length - CNT_ONE);
  assign feat_last = (feat_left == CNT_ONE);

  assign busy_o = (feat_left != '0);
  assign accept = enable_i & busy_o & ~clear_i; // enables while idle are dropped

  assign addr_d = cfg_q.base_addr + feat_off + line_off + word_off;

  always_comb begin
    mark_d.first      = (word_cnt == '0);
    mark_d.last       = word_wrap;
    mark_d.line_end   = word_wrap;
    mark_d.feat_end   = word_wrap & line_wrap;
    mark_d.final_beat = word_wrap & line_wrap & feat_last;
  end

  // loop counters and configuration
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q        <= '0;
      misalign_q   <= 1'b0;
      word_cnt     <= '0;
      line_cnt     <= '0;
      feat_left    <= '0;
      word_off     <= '0;
      line_off     <= '0;
      feat_off     <= '0;
      beat_o.valid <= 1'b0;
    end else if (clear_i) begin
      cfg_q        <= cfg_i;
      misalign_q   <= cfg_misalign(cfg_i);
      word_cnt     <= '0;
      line_cnt     <= '0;
      feat_left    <= cfg_i.feat_count; // busy from next cycle
      word_off     <= '0;
      line_off     <= '0;
      feat_off     <= '0;
      beat_o.valid <= 1'b0; // drop beat in flight
    end else begin
      beat_o.valid <= accept;
      if (accept) begin
        if (!word_wrap) begin
          word_cnt <= word_cnt + CNT_ONE;
          word_off <= word_off + `ADDRGEN_STEP;
        end else begin
          word_cnt <= '0;
          word_off <= '0;
          if (!line_wrap) begin
            line_cnt <= line_cnt + CNT_ONE;
            line_off <= line_off + line_step;
          end else begin
            // next feature, or idle after the last one
            line_cnt  <= '0;
            line_off  <= '0;
            feat_left <= feat_left - CNT_ONE;
            feat_off  <= feat_off + feat_step;
          end
        end
      end
    end
  end

  // beat payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      beat_o.addr.raw <= addr_d;
      beat_o.mark     <= mark_d;
      beat_o.misalign <= misalign_q;
    end
  end

endmodule

// File: verilog/addr_beat_if.sv
/*
 * One address beat from the loop stage to the strobe stage.
 * addr, mark and misalign are only meaningful while valid is high.
 * There is no ready, the consumer takes every valid beat.
 */

`timescale 1ns/1ps

interface addr_beat_if
  import addrgen_cfg_pkg::*;
  import addrgen_beat_pkg::*;
();

  logic       valid;
  byte_addr_u addr;     // unaligned byte address
  beat_mark_t mark;
  misalign_t  misalign; // latched for the whole transfer

  modport producer (
    output valid,
    output addr,
    output mark,
    output misalign
  );

  modport consumer (
    input valid,
    input addr,
    input mark,
    input misalign
  );

endinterface

// File: verilog/addrgen_beat_pkg.sv
/*
 * Types of one beat between the loop stage and the strobe stage.
 * The loop stage writes the address raw, the strobe stage
 * reads it back split into word index and byte offset.
 */

`include "addrgen_defs.svh"

package addrgen_beat_pkg;

  localparam int unsigned OFFS_W = $clog2(`ADDRGEN_STEP);
  localparam int unsigned WORD_W = `ADDRGEN_ADDR_W - OFFS_W;

  typedef struct packed {
    logic [WORD_W-1:0] word; // word index in memory
    logic [OFFS_W-1:0] offs; // byte inside the word
  } addr_split_t;

  typedef union packed {
    logic [`ADDRGEN_ADDR_W-1:0] raw;
    addr_split_t                split;
  } byte_addr_u;

  // position of a beat in the loop nest
  typedef struct packed {
    logic first;      // w == 0
    logic last;       // last word slot of the line
    logic line_end;   // same as last, kept for the line level
    logic feat_end;   // last beat of a feature
    logic final_beat; // last beat of the transfer
  } beat_mark_t;

endpackage

// File: verilog/addrgen_cfg_pkg.sv
/*
 * Host-side configuration of the address generator.
 * Latched as a whole by the loop stage on clear.
 * Lengths count from 1, strides are signed byte offsets.
 */

`include "addrgen_defs.svh"

package addrgen_cfg_pkg;

  typedef struct packed {
    logic        [`ADDRGEN_ADDR_W-1:0] base_addr;
    logic        [`ADDRGEN_CNT_W-1:0]  line_length; // words per line
    logic signed [`ADDRGEN_CNT_W-1:0]  line_stride; // bytes
    logic        [`ADDRGEN_CNT_W-1:0]  feat_length; // lines per feature
    logic signed [`ADDRGEN_CNT_W-1:0]  feat_stride; // bytes
    logic        [`ADDRGEN_CNT_W-1:0]  feat_count;  // number of features
  } addrgen_cfg_t;

  // set when some address in the walk can fall off a word boundary
  typedef logic misalign_t;

  // any of base and strides with low offset bits set
  function automatic misalign_t cfg_misalign(input addrgen_cfg_t cfg);
    return ((cfg.base_addr   & (`ADDRGEN_STEP - 1)) != 0) ||
           ((cfg.line_stride & (`ADDRGEN_STEP - 1)) != 0) ||
           ((cfg.feat_stride & (`ADDRGEN_STEP - 1)) != 0);
  endfunction

endpackage

// File: verilog/addrgen_defs.svh
/*
 * Global sizes for the strided address generator.
 * Included by the packages and by every module that sizes ports.
 * Word size and strobe width both follow ADDRGEN_STEP.
 */

`ifndef ADDRGEN_DEFS_SVH
`define ADDRGEN_DEFS_SVH

// byte address width of the memory side
`define ADDRGEN_ADDR_W 32

// bytes per memory word
// also the strobe width and the word increment
`define ADDRGEN_STEP 4

// width of the word, line and feature counters
// and of the lengths and strides loaded by the host
`define ADDRGEN_CNT_W 16

`endif
